// File: src.f
+incdir+include
source/execPkg.sv
source/barrelShifter.sv
source/aluDecoder.sv
source/alu.sv
source/flagRegister.sv
source/executeStage.sv
tb/executeStageTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module executeStageTb \
  -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The log decides the outcome
if grep -q "Done: errors found" sim.log; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
exit 0

// File: tb/executeStageTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_config.svh"

module executeStageTb import execPkg::*; ();

  localparam int W = `DATA_WIDTH;

  typedef struct {
    string                  name;
    dpOpcodeT               op;
    logic                   setFlags;
    logic [W-1:0]           a;
    logic [W-1:0]           b;
    shiftTypeT              shiftKind;
    logic [`SHIFT_BITS-1:0] amount;
    logic [W-1:0]           expResult;
    logic                   expValid;
    logic [3:0]             expFlags;    // NZCV after the edge
  } recordT;

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   instrValid;
  logic                   setFlags;
  dpOpcodeT               opcode;
  logic [W-1:0]           operandA;
  logic [W-1:0]           operandB;
  shiftTypeT              shiftType;
  logic [`SHIFT_BITS-1:0] shiftAmount;
  logic [W-1:0]           result;
  logic                   resultValid;
  logic [3:0]             flags;

  recordT   records[$];
  int       cycleCount = 0;
  int       checkCount = 0;
  int       errorCount = 0;
  dpOpcodeT randOps[4] = '{DP_ADD, DP_SUB, DP_AND, DP_MOV};

  executeStage DUT (
    .clk         (clk),
    .reset       (reset),
    .instrValid  (instrValid),
    .setFlags    (setFlags),
    .opcode      (opcode),
    .operandA    (operandA),
    .operandB    (operandB),
    .shiftType   (shiftType),
    .shiftAmount (shiftAmount),
    .result      (result),
    .resultValid (resultValid),
    .flags       (flags)
  );

  always #4 clk = ~clk;                        // 8 ns period with rising edges at 4 + 8k
  always @(posedge clk) cycleCount <= cycleCount + 1;

  // Polls on odd ns only so it never meets an edge and returns 1 ns past one
  task automatic nextCycle(input string where);
    int start;
    int polls;
    start = cycleCount;
    polls = 0;
    while (cycleCount == start && polls < 10) begin
      #2;
      polls++;
    end
    if (cycleCount == start) begin
      $display("Timeout: the clock made no rising edge during %s", where);
      $display("Done: errors found");
      $finish;
    end
  endtask

  task automatic checkValue(input string testName, input string signal,
                            input logic [W-1:0] expected, input logic [W-1:0] actual);
    checkCount++;
    assert (actual === expected) else begin
      $display("CHECK FAILED %s %s expected %h actual %h", testName, signal, expected, actual);
      errorCount++;
    end
  endtask

  task automatic driveInputs(input dpOpcodeT op, input logic sf, input logic [W-1:0] a,
                             input logic [W-1:0] b, input shiftTypeT kind,
                             input logic [`SHIFT_BITS-1:0] amount, input logic valid);
    opcode      = op;
    setFlags    = sf;
    operandA    = a;
    operandB    = b;
    shiftType   = kind;
    shiftAmount = amount;
    instrValid  = valid;
  endtask

  task automatic addRecord(input string name, input dpOpcodeT op, input int sf,
                           input logic [W-1:0] a, input logic [W-1:0] b, input shiftTypeT kind,
                           input int amount, input logic [W-1:0] res, input int rv,
                           input logic [3:0] nzcv);
    recordT rec;
    rec.name      = name;
    rec.op        = op;
    rec.setFlags  = sf[0];
    rec.a         = a;
    rec.b         = b;
    rec.shiftKind = kind;
    rec.amount    = amount[`SHIFT_BITS-1:0];
    rec.expResult = res;
    rec.expValid  = rv[0];
    rec.expFlags  = nzcv;
    records.push_back(rec);
  endtask

  // Flags chain from one row to the next and start at 0000
  task automatic buildTable();
    addRecord("add basic", DP_ADD, 1, 'h00000005, 'h00000003, SHIFT_LSL, 0, 'h00000008, 1, 4'b0000);
    addRecord("add carry", DP_ADD, 1, 'hFFFFFFFF, 'h00000001, SHIFT_LSL, 0, 'h00000000, 1, 4'b0110);
    addRecord("add ovf",   DP_ADD, 1, 'h7FFFFFFF, 'h00000001, SHIFT_LSL, 0, 'h80000000, 1, 4'b1001);
    addRecord("sub ovf",   DP_SUB, 1, 'h80000000, 'h00000001, SHIFT_LSL, 0, 'h7FFFFFFF, 1, 4'b0011);
    addRecord("sub borrow", DP_SUB, 1, 'h00000003, 'h00000005, SHIFT_LSL, 0, 'hFFFFFFFE, 1, 4'b1000);
    addRecord("rsb",       DP_RSB, 1, 'h00000002, 'h0000000A, SHIFT_LSL, 0, 'h00000008, 1, 4'b0010);
    addRecord("cmp equal", DP_CMP, 1, 'h00000007, 'h00000007, SHIFT_LSL, 0, 'h00000000, 0, 4'b0110);
    addRecord("cmn ovf",   DP_CMN, 1, 'h7FFFFFFF, 'h00000001, SHIFT_LSL, 0, 'h80000000, 0, 4'b1001);
    addRecord("add cout",  DP_ADD, 1, 'hFFFFFFFF, 'h00000002, SHIFT_LSL, 0, 'h00000001, 1, 4'b0010);
    addRecord("adc c1",    DP_ADC, 1, 'h00000001, 'h00000001, SHIFT_LSL, 0, 'h00000003, 1, 4'b0000);
    addRecord("sub c0",    DP_SUB, 1, 'h00000000, 'h00000001, SHIFT_LSL, 0, 'hFFFFFFFF, 1, 4'b1000);
    addRecord("sbc c0",    DP_SBC, 1, 'h0000000A, 'h00000003, SHIFT_LSL, 0, 'h00000006, 1, 4'b0010);
    addRecord("rsc c1",    DP_RSC, 1, 'h00000003, 'h0000000A, SHIFT_LSL, 0, 'h00000007, 1, 4'b0010);
    addRecord("add no s",  DP_ADD, 0, 'hFFFFFFFF, 'hFFFFFFFF, SHIFT_LSL, 0, 'hFFFFFFFE, 1, 4'b0010);
    addRecord("add v",     DP_ADD, 1, 'h7FFFFFFF, 'h7FFFFFFF, SHIFT_LSL, 0, 'hFFFFFFFE, 1, 4'b1001);
    addRecord("and",       DP_AND, 1, 'hF0F0F0F0, 'hFF00FF00, SHIFT_LSL, 0, 'hF000F000, 1, 4'b1001);
    addRecord("eor lsl",   DP_EOR, 1, 'hFFFF0000, 'h80000001, SHIFT_LSL, 1, 'hFFFF0002, 1, 4'b1011);
    addRecord("orr zero",  DP_ORR, 1, 'h00000000, 'h00000000, SHIFT_LSL, 0, 'h00000000, 1, 4'b0111);
    addRecord("bic lsr",   DP_BIC, 1, 'hFFFFFFFF, 'h0000FFFF, SHIFT_LSR, 4, 'hFFFFF000, 1, 4'b1011);
    addRecord("mov asr",   DP_MOV, 1, 'h00000000, 'h80000010, SHIFT_ASR, 4, 'hF8000001, 1, 4'b1001);
    addRecord("mvn ror",   DP_MVN, 1, 'h00000000, 'hFFFFFFFF, SHIFT_ROR, 8, 'h00000000, 1, 4'b0111);
    addRecord("tst",       DP_TST, 1, 'h80000000, 'h80000000, SHIFT_LSL, 0, 'h80000000, 0, 4'b1011);
    addRecord("teq",       DP_TEQ, 1, 'h12345678, 'h12345678, SHIFT_LSL, 0, 'h00000000, 0, 4'b0111);
    addRecord("lsl 4",     DP_MOV, 1, 'h00000000, 'h12345678, SHIFT_LSL, 4, 'h23456780, 1, 4'b0011);
    addRecord("lsr 1",     DP_MOV, 1, 'h00000000, 'h00000002, SHIFT_LSR, 1, 'h00000001, 1, 4'b0001);
    addRecord("asr 31",    DP_MOV, 1, 'h00000000, 'h80000000, SHIFT_ASR, 31, 'hFFFFFFFF, 1, 4'b1001);
    addRecord("ror 16",    DP_MOV, 1, 'h00000000, 'h0000ABCD, SHIFT_ROR, 16, 'hABCD0000, 1, 4'b1011);
    addRecord("ror 0",     DP_MOV, 1, 'h00000000, 'h00000001, SHIFT_ROR, 0, 'h00000001, 1, 4'b0011);
    addRecord("asr 1",     DP_MOV, 1, 'h00000000, 'h00000004, SHIFT_ASR, 1, 'h00000002, 1, 4'b0001);
    addRecord("lsr 0",     DP_MOV, 1, 'h00000000, 'h80000001, SHIFT_LSR, 0, 'h80000001, 1, 4'b1001);
  endtask

  // One bit per step so the carry is simply the last bit that fell off
  function automatic logic [W:0] shiftModel(input logic [W-1:0] value, input shiftTypeT kind,
                                            input logic [`SHIFT_BITS-1:0] amount,
                                            input logic carryIn);
    logic [W-1:0] v;
    logic         c;
    v = value;
    c = carryIn;                               // Kept when amount is 0
    for (int i = 0; i < int'(amount); i++) begin
      case (kind)
        SHIFT_LSL: begin
          c = v[W-1];
          v = {v[W-2:0], 1'b0};
        end
        SHIFT_LSR: begin
          c = v[0];
          v = {1'b0, v[W-1:1]};
        end
        SHIFT_ASR: begin
          c = v[0];
          v = {v[W-1], v[W-1:1]};
        end
        default: begin
          c = v[0];
          v = {v[0], v[W-1:1]};
        end
      endcase
    end
    return {c, v};
  endfunction

  // Returns {NZCV, result} for the random subset ADD, SUB, AND, MOV
  function automatic logic [W+3:0] aluModel(input dpOpcodeT op, input logic [W-1:0] a,
                                            input logic [W-1:0] b, input logic shiftCarry,
                                            input logic [3:0] oldFlags);
    logic [W:0]   wide;
    logic [W-1:0] r;
    logic         c;
    logic         v;
    c = shiftCarry;                            // Logic ops take the shifter carry
    v = oldFlags[`FLAG_V];
    case (op)
      DP_ADD: begin
        wide = {1'b0, a} + {1'b0, b};
        r    = wide[W-1:0];
        c    = wide[W];
        v    = (a[W-1] == b[W-1]) && (r[W-1] != a[W-1]);
      end
      DP_SUB: begin
        r = a - b;
        c = (a >= b);                          // No borrow
        v = (a[W-1] != b[W-1]) && (r[W-1] != a[W-1]);
      end
      DP_AND: r = a & b;
      default: r = b;
    endcase
    return {r[W-1], (r == '0), c, v, r};
  endfunction

  initial begin
    recordT                 rec;
    logic [W-1:0]           r;
    logic [W-1:0]           randA;
    logic [W-1:0]           randB;
    dpOpcodeT               randOp;
    shiftTypeT              randKind;
    logic [`SHIFT_BITS-1:0] randAmount;
    logic                   randSf;
    logic                   randValid;
    logic [W:0]             shiftOut;
    logic [W+3:0]           modelOut;
    logic [3:0]             modelFlags;
    string                  name;

    void'($urandom(72));
    reset = 1'b1;
    driveInputs(DP_AND, 1'b0, '0, '0, SHIFT_LSL, '0, 1'b0);
    buildTable();

    #1;                                        // Move to odd ns
    repeat (8) nextCycle("reset");
    reset = 1'b0;

    // Flag-setting ADD with instrValid low changes nothing
    driveInputs(DP_ADD, 1'b1, '1, 32'h1, SHIFT_LSL, '0, 1'b0);
    #4;
    checkValue("after reset", "flags", '0, W'(flags));
    checkValue("idle", "resultValid", '0, W'(resultValid));
    nextCycle("idle");
    checkValue("idle", "flags", '0, W'(flags));

    foreach (records[i]) begin
      rec = records[i];
      driveInputs(rec.op, rec.setFlags, rec.a, rec.b, rec.shiftKind, rec.amount, 1'b1);
      #4;                                      // Combinational outputs settled by mid-cycle
      checkValue(rec.name, "result", rec.expResult, result);
      checkValue(rec.name, "resultValid", W'(rec.expValid), W'(resultValid));
      nextCycle(rec.name);
      checkValue(rec.name, "flags", W'(rec.expFlags), W'(flags));
    end

    modelFlags = records[records.size()-1].expFlags;
    for (int n = 0; n < 200; n++) begin
      name       = $sformatf("random %0d", n);
      r          = $urandom;
      randA      = $urandom;
      randB      = $urandom;
      randOp     = randOps[r[1:0]];
      randKind   = shiftTypeT'(r[3:2]);
      randAmount = r[8:4];
      randSf     = r[9];
      randValid  = (r[12:10] != 3'b000);       // Mostly valid with a few idle slots
      driveInputs(randOp, randSf, randA, randB, randKind, randAmount, randValid);
      shiftOut = shiftModel(randB, randKind, randAmount, modelFlags[`FLAG_C]);
      modelOut = aluModel(randOp, randA, shiftOut[W-1:0], shiftOut[W], modelFlags);
      #4;
      if (randValid) begin
        checkValue(name, "result", modelOut[W-1:0], result);
      end
      checkValue(name, "resultValid", W'(randValid), W'(resultValid));
      if (randValid && randSf) begin
        modelFlags = modelOut[W+3:W];
      end
      nextCycle(name);
      checkValue(name, "flags", W'(modelFlags), W'(flags));
    end

    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_config.svh"

module executeStage import execPkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   instrValid,
  input  logic                   setFlags,     // S bit
  input  dpOpcodeT               opcode,
  input  logic [`DATA_WIDTH-1:0] operandA,     // Rn
  input  logic [`DATA_WIDTH-1:0] operandB,     // Rm or immediate before shift
  input  shiftTypeT              shiftType,
  input  logic [`SHIFT_BITS-1:0] shiftAmount,
  output logic [`DATA_WIDTH-1:0] result,
  output logic                   resultValid,
  output logic [3:0]             flags         // NZCV
);

  logic [`DATA_WIDTH-1:0] shiftedB;
  logic                   shifterCarry;
  aluOpT                  aluOperation;
  logic                   invertB;
  logic                   reverseInputs;
  carrySelT               carrySel;
  cvUpdateT               cvUpdate;
  logic                   writesResult;
  logic [3:0]             nextFlags;
  logic                   flagUpdate;

  assign flagUpdate  = instrValid & setFlags;
  assign resultValid = instrValid & writesResult;

  barrelShifter shifter (
    .value       (operandB),
    .shiftType   (shiftType),
    .shiftAmount (shiftAmount),
    .carryIn     (flags[`FLAG_C]),   // Passed through on amount 0
    .shifted     (shiftedB),
    .carryOut    (shifterCarry)
  );

  aluDecoder decoder (
    .opcode        (opcode),
    .aluOperation  (aluOperation),
    .invertB       (invertB),
    .reverseInputs (reverseInputs),
    .carrySel      (carrySel),
    .cvUpdate      (cvUpdate),
    .writesResult  (writesResult)
  );

  alu aluCore (
    .a                (operandA),
    .b                (shiftedB),
    .aluOperation     (aluOperation),
    .invertB          (invertB),
    .reverseInputs    (reverseInputs),
    .carrySel         (carrySel),
    .cvUpdate         (cvUpdate),
    .shifterCarry     (shifterCarry),
    .previousCarry    (flags[`FLAG_C]),
    .previousOverflow (flags[`FLAG_V]),
    .result           (result),
    .nextFlags        (nextFlags)
  );

  flagRegister flagReg (
    .clk       (clk),
    .reset     (reset),
    .update    (flagUpdate),
    .nextFlags (nextFlags),
    .flags     (flags)
  );

endmodule

`default_nettype wire

// File: source/flagRegister.sv
`timescale 1ns/1ns
`default_nettype none

module flagRegister (
  input  logic       clk,
  input  logic       reset,      // Synchronous, active high
  input  logic       update,     // Flag-setting instruction this cycle
  input  logic [3:0] nextFlags,  // NZCV from the ALU
  output logic [3:0] flags
);

  // NZCV state, also the carry and overflow source for the next instruction
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= 4'b0000;
    end else if (update) begin
      flags <= nextFlags;
    end
  end

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_config.svh"

module alu import execPkg::*; (
  input  logic [`DATA_WIDTH-1:0] a,
  input  logic [`DATA_WIDTH-1:0] b,                // Shifted operand B
  input  aluOpT                  aluOperation,
  input  logic                   invertB,
  input  logic                   reverseInputs,
  input  carrySelT               carrySel,
  input  cvUpdateT               cvUpdate,
  input  logic                   shifterCarry,
  input  logic                   previousCarry,    // Stored C
  input  logic                   previousOverflow, // Stored V
  output logic [`DATA_WIDTH-1:0] result,
  output logic [3:0]             nextFlags         // NZCV
);

  logic [`DATA_WIDTH-1:0] opA;
  logic [`DATA_WIDTH-1:0] opB;
  logic [`DATA_WIDTH-1:0] condInvB;
  logic [`DATA_WIDTH:0]   sum;          // MSB is adder carry out
  logic                   carryIn;
  logic                   addOverflow;
  logic                   subOverflow;
  logic                   carryFlag;
  logic                   overflowFlag;

  // Operand swap for reverse subtract
  assign opA = reverseInputs ? b : a;
  assign opB = reverseInputs ? a : b;

  assign condInvB = invertB ? ~opB : opB;

  always_comb begin
    case (carrySel)
      CARRY_ONE:  carryIn = 1'b1;
      CARRY_FLAG: carryIn = previousCarry;
      default:    carryIn = 1'b0;
    endcase
  end

  assign sum = {1'b0, opA} + {1'b0, condInvB} + {{`DATA_WIDTH{1'b0}}, carryIn};

  always_comb begin
    case (aluOperation)
      ALU_AND:          result = opA & condInvB;
      ALU_XOR:          result = opA ^ condInvB;
      ALU_OR:           result = opA | condInvB;
      ALU_PASSB:        result = condInvB;
      ALU_PASSB_CLEAR0: result = {condInvB[`DATA_WIDTH-1:1], 1'b0};
      default:          result = sum[`DATA_WIDTH-1:0];
    endcase
  end

  // Sign rules use B before inversion
  assign subOverflow = (opA[`DATA_WIDTH-1] ^ opB[`DATA_WIDTH-1]) &
                       (opA[`DATA_WIDTH-1] ^ sum[`DATA_WIDTH-1]);
  assign addOverflow = ~(opA[`DATA_WIDTH-1] ^ opB[`DATA_WIDTH-1]) &
                       (opA[`DATA_WIDTH-1] ^ sum[`DATA_WIDTH-1]);

  always_comb begin
    case (cvUpdate)
      CV_SUBTRACT: begin
        carryFlag    = sum[`DATA_WIDTH];   // Set means no borrow
        overflowFlag = subOverflow;
      end
      CV_ADD, CV_COMPARE_NEG: begin
        carryFlag    = sum[`DATA_WIDTH];
        overflowFlag = addOverflow;
      end
      CV_LOGIC: begin
        carryFlag    = shifterCarry;
        overflowFlag = previousOverflow;   // V untouched by logic ops
      end
      default: begin
        carryFlag    = previousCarry;
        overflowFlag = previousOverflow;
      end
    endcase
  end

  assign nextFlags = {result[`DATA_WIDTH-1], (result == '0), carryFlag, overflowFlag};

endmodule

`default_nettype wire

// File: source/aluDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module aluDecoder import execPkg::*; (
  input  dpOpcodeT opcode,
  output aluOpT    aluOperation,
  output logic     invertB,
  output logic     reverseInputs,
  output carrySelT carrySel,
  output cvUpdateT cvUpdate,
  output logic     writesResult   // Low for TST, TEQ, CMP, CMN
);

  always_comb begin
    // Plain logical op writing its result
    aluOperation  = ALU_AND;
    invertB       = 1'b0;
    reverseInputs = 1'b0;
    carrySel      = CARRY_ZERO;
    cvUpdate      = CV_LOGIC;
    writesResult  = 1'b1;

    case (opcode)
      DP_AND: aluOperation = ALU_AND;
      DP_EOR: aluOperation = ALU_XOR;
      DP_SUB: begin                       // A + ~B + 1
        aluOperation = ALU_SUM;
        invertB      = 1'b1;
        carrySel     = CARRY_ONE;
        cvUpdate     = CV_SUBTRACT;
      end
      DP_RSB: begin                       // B + ~A + 1
        aluOperation  = ALU_SUM;
        reverseInputs = 1'b1;
        invertB       = 1'b1;
        carrySel      = CARRY_ONE;
        cvUpdate      = CV_SUBTRACT;
      end
      DP_ADD: begin
        aluOperation = ALU_SUM;
        cvUpdate     = CV_ADD;
      end
      DP_ADC: begin
        aluOperation = ALU_SUM;
        carrySel     = CARRY_FLAG;
        cvUpdate     = CV_ADD;
      end
      DP_SBC: begin                       // A + ~B + C
        aluOperation = ALU_SUM;
        invertB      = 1'b1;
        carrySel     = CARRY_FLAG;
        cvUpdate     = CV_SUBTRACT;
      end
      DP_RSC: begin                       // B + ~A + C
        aluOperation  = ALU_SUM;
        reverseInputs = 1'b1;
        invertB       = 1'b1;
        carrySel      = CARRY_FLAG;
        cvUpdate      = CV_SUBTRACT;
      end
      DP_TST: writesResult = 1'b0;        // AND, flags only
      DP_TEQ: begin
        aluOperation = ALU_XOR;
        writesResult = 1'b0;
      end
      DP_CMP: begin
        aluOperation = ALU_SUM;
        invertB      = 1'b1;
        carrySel     = CARRY_ONE;
        cvUpdate     = CV_SUBTRACT;
        writesResult = 1'b0;
      end
      DP_CMN: begin
        aluOperation = ALU_SUM;
        cvUpdate     = CV_COMPARE_NEG;
        writesResult = 1'b0;
      end
      DP_ORR: aluOperation = ALU_OR;
      DP_MOV: aluOperation = ALU_PASSB;
      DP_BIC: invertB = 1'b1;             // A & ~B
      DP_MVN: begin
        aluOperation = ALU_PASSB;
        invertB      = 1'b1;
      end
      default: writesResult = 1'b0;       // Unknown opcode writes nothing
    endcase
  end

endmodule

`default_nettype wire

// File: source/barrelShifter.sv
`timescale 1ns/1ns
`default_nettype none

`include "exec_config.svh"

module barrelShifter import execPkg::*; (
  input  logic [`DATA_WIDTH-1:0] value,        // Operand B before shift
  input  shiftTypeT              shiftType,
  input  logic [`SHIFT_BITS-1:0] shiftAmount,
  input  logic                   carryIn,      // Current C flag
  output logic [`DATA_WIDTH-1:0] shifted,
  output logic                   carryOut
);

  // Each shift carries one guard bit that catches the last bit shifted out
  logic        [`DATA_WIDTH:0]     lslWide;      // Top bit is the carry
  logic        [`DATA_WIDTH:0]     lsrWide;      // Bottom bit is the carry
  logic signed [`DATA_WIDTH:0]     asrWide;      // Bottom bit is the carry
  logic        [2*`DATA_WIDTH-1:0] rorWide;      // Value doubled for rotate
  logic                            typeCarry;

  assign lslWide = {1'b0, value} << shiftAmount;
  assign lsrWide = {value, 1'b0} >> shiftAmount;
  assign asrWide = $signed({value, 1'b0}) >>> shiftAmount;  // Sign bit fills from the top
  assign rorWide = {value, value} >> shiftAmount;

  // Select shifted value and its carry by type
  always_comb begin
    case (shiftType)
      SHIFT_LSL: begin
        shifted   = lslWide[`DATA_WIDTH-1:0];
        typeCarry = lslWide[`DATA_WIDTH];      // value[W-amount]
      end
      SHIFT_LSR: begin
        shifted   = lsrWide[`DATA_WIDTH:1];
        typeCarry = lsrWide[0];                // value[amount-1]
      end
      SHIFT_ASR: begin
        shifted   = asrWide[`DATA_WIDTH:1];
        typeCarry = asrWide[0];
      end
      SHIFT_ROR: begin
        shifted   = rorWide[`DATA_WIDTH-1:0];
        typeCarry = rorWide[`DATA_WIDTH-1];    // Bit that wrapped into the MSB
      end
      default: begin
        shifted   = value;
        typeCarry = carryIn;
      end
    endcase
  end

  // Amount 0 is a plain pass, shifted already equals value here
  assign carryOut = (shiftAmount == '0) ? carryIn : typeCarry;

endmodule

`default_nettype wire

// File: source/execPkg.sv
`default_nettype none

package execPkg;

  // Data-processing opcode, ARM instruction bits [24:21]
  typedef enum logic [3:0] {
    DP_AND = 4'h0, DP_EOR = 4'h1, DP_SUB = 4'h2, DP_RSB = 4'h3,
    DP_ADD = 4'h4, DP_ADC = 4'h5, DP_SBC = 4'h6, DP_RSC = 4'h7,
    DP_TST = 4'h8, DP_TEQ = 4'h9, DP_CMP = 4'hA, DP_CMN = 4'hB,
    DP_ORR = 4'hC, DP_MOV = 4'hD, DP_BIC = 4'hE, DP_MVN = 4'hF
  } dpOpcodeT;

  // ALU result select
  typedef enum logic [2:0] {
    ALU_AND          = 3'b000,
    ALU_XOR          = 3'b001,
    ALU_SUM          = 3'b010,
    ALU_OR           = 3'b011,
    ALU_PASSB        = 3'b100,
    ALU_PASSB_CLEAR0 = 3'b101  // B with bit 0 forced low
  } aluOpT;

  // How C and V are formed
  typedef enum logic [2:0] {
    CV_LOGIC       = 3'b000,  // C from shifter, V kept
    CV_COMPARE_NEG = 3'b100,  // CMN, add overflow rule
    CV_SUBTRACT    = 3'b101,  // Subtract overflow rule
    CV_ADD         = 3'b110   // Add overflow rule
  } cvUpdateT;

  typedef enum logic [1:0] {
    SHIFT_LSL = 2'b00,
    SHIFT_LSR = 2'b01,
    SHIFT_ASR = 2'b10,
    SHIFT_ROR = 2'b11
  } shiftTypeT;

  // Adder carry-in source
  typedef enum logic [1:0] {
    CARRY_ZERO = 2'b00,
    CARRY_ONE  = 2'b01,
    CARRY_FLAG = 2'b10   // Stored C flag
  } carrySelT;

endpackage

`default_nettype wire

// File: include/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Operand, shifter and result width
`define DATA_WIDTH 32

// Shift amount width, covers amounts 0 to 31
`define SHIFT_BITS 5

// Flag vector is NZCV, bit 3 down to bit 0
`define FLAG_N 3
`define FLAG_Z 2
`define FLAG_C 1
`define FLAG_V 0
`endif
